//--- files.f
hw/gpio_pkg.sv
hw/gpio_out_regs.sv
hw/gpio_in_event.sv
hw/gpio.sv
hw/gpio_apb.sv
bench/gpio_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the GPIO testbench with Verilator, run it and check the log.
# Exits non-zero when the build fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f files.f --top-module gpio_tb > build.log 2>&1 \
    && ./obj_dir/Vgpio_tb | tee sim.log \
    && grep -q "^TEST PASSED$" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

exit 0

//--- bench/gpio_tb.sv
/*
 * Testbench for the APB GPIO peripheral.
 * Applies a table of bus writes, reads, pin changes and waits to the DUT
 * and compares read data, slave errors, pin outputs and the interrupt
 * with values from a small register model. Ends with an error summary.
 */

`timescale 1ns/1ns

module gpio_tb;

    localparam integer      clk_half     = 4;             // 8 ns period
    localparam integer      reset_cycles = 5;
    localparam logic [31:0] rand_seed    = 32'h829d_7cba;

    typedef enum logic [2 : 0] {
        op_wr,                                           // apb write
        op_rd,                                           // apb read
        op_pins,                                         // drive fixed pin value
        op_rpins,                                        // drive random pin value
        op_wait                                          // idle for data cycles
    } op_e;

    typedef struct packed {
        op_e           op;
        logic [4 : 0]  addr;
        logic [31 : 0] data;
        logic [31 : 0] exp_rd;                           // ignored for reg_gpi reads
        logic          exp_err;                          // expected pslverr
        logic          exp_irq;                          // irq at end of step
    } step_t;

    logic                          clk;
    logic                          rst_n;
    logic [4 : 0]                  paddr;
    logic [31 : 0]                 prdata;
    logic [31 : 0]                 pwdata;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic                          pready;
    logic                          pslverr;
    logic                          irq;
    logic [gpio_pkg::gpio_w-1 : 0] gpi;
    logic [gpio_pkg::gpio_w-1 : 0] gpo;
    logic [gpio_pkg::gpio_w-1 : 0] gpd;

    step_t                         steps[$];             // stimulus table
    logic [gpio_pkg::gpio_w-1 : 0] m_gpo;                // model of output data
    logic [gpio_pkg::gpio_w-1 : 0] m_gpd;                // model of direction
    logic [gpio_pkg::gpio_w-1 : 0] m_pins;               // last value driven on gpi
    integer                        errors;
    integer                        checks;

    gpio_apb dut (
        .pclk       ( clk       ),
        .rst_n      ( rst_n     ),
        .paddr      ( paddr     ),
        .prdata     ( prdata    ),
        .pwdata     ( pwdata    ),
        .psel       ( psel      ),
        .penable    ( penable   ),
        .pwrite     ( pwrite    ),
        .pready     ( pready    ),
        .pslverr    ( pslverr   ),
        .irq        ( irq       ),
        .gpi        ( gpi       ),
        .gpo        ( gpo       ),
        .gpd        ( gpd       )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    task automatic add_step(input op_e op, input logic [4 : 0] addr, input logic [31 : 0] data,
                            input logic [31 : 0] exp_rd, input logic exp_err, input logic exp_irq);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.exp_rd  = exp_rd;
        s.exp_err = exp_err;
        s.exp_irq = exp_irq;
        steps.push_back(s);
    endtask

    task automatic check_data(input string name, input logic [gpio_pkg::gpio_w-1 : 0] got,
                              input logic [gpio_pkg::gpio_w-1 : 0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rsp(input string name, input gpio_pkg::gpio_rsp_t got,
                             input gpio_pkg::gpio_rsp_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error: %s prdata 0x%h pslverr 0x%h expected 0x%h 0x%h at %0t",
                     name, got.rd, got.bad, exp.rd, exp.bad, $time);
        end
    endtask

    task automatic apb_write(input logic [4 : 0] addr, input logic [31 : 0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;                                 // setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;                                 // access phase
        @(negedge clk);
        while (!pready) @(negedge clk);                  // wait for the slave to finish
        err = pslverr;
        @(posedge clk);                                  // write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [4 : 0] addr, output gpio_pkg::gpio_rsp_t rsp);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        rsp.rd  = prdata;                                // sampled mid access cycle
        rsp.bad = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic build_table;
        // output registers
        add_step(op_wr,    gpio_pkg::reg_gpo,     32'h0000_00a5, 32'h0,  1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_gpd,     32'h0000_003c, 32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpo,     32'h0,         32'ha5, 1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpd,     32'h0,         32'h3c, 1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_gpo,     32'h0000_005a, 32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpo,     32'h0,         32'h5a, 1'b0, 1'b0);
        // random pins read back, only rising edges while polarity is falling
        add_step(op_rpins, 5'h00,                 32'h0,         32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpi,     32'h0,         32'h0,  1'b0, 1'b0);
        // rising edge interrupt
        add_step(op_wr,    gpio_pkg::reg_irq_en,  32'h0000_00ff, 32'h0,  1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_irq_pol, 32'h0000_00ff, 32'h0,  1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_irq_st,  32'h0000_00ff, 32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h0,  1'b0, 1'b0);
        add_step(op_pins,  5'h00,                 32'h00,        32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b0);
        add_step(op_pins,  5'h00,                 32'h01,        32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b1);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h01, 1'b0, 1'b1);
        add_step(op_wr,    gpio_pkg::reg_irq_st,  32'h0000_0001, 32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h0,  1'b0, 1'b0);
        // falling polarity on pin 0, then masking
        add_step(op_wr,    gpio_pkg::reg_irq_pol, 32'h0000_00fe, 32'h0,  1'b0, 1'b0);
        add_step(op_pins,  5'h00,                 32'h00,        32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b1);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h01, 1'b0, 1'b1);
        add_step(op_wr,    gpio_pkg::reg_irq_st,  32'h0000_0001, 32'h0,  1'b0, 1'b0);
        add_step(op_pins,  5'h00,                 32'h01,        32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h0,  1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_irq_en,  32'h0000_00fe, 32'h0,  1'b0, 1'b0);
        add_step(op_pins,  5'h00,                 32'h00,        32'h0,  1'b0, 1'b0);
        add_step(op_wait,  5'h00,                 32'd6,         32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_st,  32'h0,         32'h01, 1'b0, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_irq_st,  32'h0000_0001, 32'h0,  1'b0, 1'b0);
        // bad accesses leave every register alone
        add_step(op_wr,    5'h18,                 32'h0000_00ff, 32'h0,  1'b1, 1'b0);
        add_step(op_rd,    5'h18,                 32'h0,         32'h0,  1'b1, 1'b0);
        add_step(op_wr,    5'h1c,                 32'h0000_00ff, 32'h0,  1'b1, 1'b0);
        add_step(op_rd,    5'h1c,                 32'h0,         32'h0,  1'b1, 1'b0);
        add_step(op_wr,    gpio_pkg::reg_gpi,     32'h0000_00ff, 32'h0,  1'b1, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpi,     32'h0,         32'h0,  1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpo,     32'h0,         32'h5a, 1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_gpd,     32'h0,         32'h3c, 1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_en,  32'h0,         32'hfe, 1'b0, 1'b0);
        add_step(op_rd,    gpio_pkg::reg_irq_pol, 32'h0,         32'hfe, 1'b0, 1'b0);
    endtask

    // main sequence
    initial begin
        integer              idx;
        logic                err;
        logic [31 : 0]       rnd;
        gpio_pkg::gpio_rsp_t rsp;
        gpio_pkg::gpio_rsp_t exp_rsp;
        gpio_pkg::gpio_rsp_t idle_rsp;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        gpi     = '0;
        m_gpo   = '0;                                    // reset values
        m_gpd   = '0;
        m_pins  = '0;
        errors  = 0;
        checks  = 0;
        void'($urandom(rand_seed));                      // one seed for the whole run
        build_table();

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        for (idx = 0; idx < steps.size(); idx = idx + 1) begin
            case (steps[idx].op)
                op_wr: begin
                    apb_write(steps[idx].addr, steps[idx].data, err);
                    check_flag("pslverr", err, steps[idx].exp_err);
                    if (steps[idx].addr == gpio_pkg::reg_gpo) begin
                        m_gpo = steps[idx].data[gpio_pkg::gpio_w-1 : 0];
                    end else if (steps[idx].addr == gpio_pkg::reg_gpd) begin
                        m_gpd = steps[idx].data[gpio_pkg::gpio_w-1 : 0];
                    end
                end
                op_rd: begin
                    apb_read(steps[idx].addr, rsp);
                    exp_rsp.rd  = (steps[idx].addr == gpio_pkg::reg_gpi) ?
                                  32'(m_pins) : steps[idx].exp_rd;   // pins settled by now
                    exp_rsp.bad = steps[idx].exp_err;
                    check_rsp("read", rsp, exp_rsp);
                end
                op_pins: begin
                    @(posedge clk);
                    gpi    <= steps[idx].data[gpio_pkg::gpio_w-1 : 0];
                    m_pins  = steps[idx].data[gpio_pkg::gpio_w-1 : 0];
                end
                op_rpins: begin
                    rnd = $urandom;
                    @(posedge clk);
                    gpi    <= rnd[gpio_pkg::gpio_w-1 : 0];
                    m_pins  = rnd[gpio_pkg::gpio_w-1 : 0];
                end
                default: begin
                    repeat (steps[idx].data) @(posedge clk);
                end
            endcase
            @(negedge clk);                              // outputs settled after last edge
            check_data("gpo", gpo, m_gpo);
            check_data("gpd", gpd, m_gpd);
            check_flag("irq", irq, steps[idx].exp_irq);
            idle_rsp.rd  = prdata;                       // bus idle between transfers
            idle_rsp.bad = pslverr;
            check_rsp("idle bus", idle_rsp, '0);
            check_flag("pready", pready, 1'b0);
        end

        $display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, ten cycles per table row plus reset
    initial begin
        #1;
        repeat ((steps.size() * 10) + reset_cycles + 10) @(posedge clk);
        $display("watchdog expired, the stimulus table did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule : gpio_tb

//--- hw/gpio_apb.sv
/*
 * Top level of the GPIO peripheral, an APB slave around the register core.
 * Every transfer completes in its first access cycle. Read data and the
 * error flag are only driven during the access phase.
 */

`timescale 1ns/1ns

module gpio_apb (
    input  logic                              pclk,     // apb clock
    input  logic                              rst_n,    // sync reset, active low
    input  logic [4 : 0]                      paddr,    // word address
    output logic [31 : 0]                     prdata,   // read data
    input  logic [31 : 0]                     pwdata,   // write data
    input  logic                              psel,     // slave select
    input  logic                              penable,  // access phase
    input  logic                              pwrite,   // 1 = write
    output logic                              pready,   // no wait states
    output logic                              pslverr,  // bad access
    output logic                              irq,      // level interrupt
    input  logic [gpio_pkg::gpio_w-1 : 0]     gpi,      // pin input
    output logic [gpio_pkg::gpio_w-1 : 0]     gpo,      // pin output data
    output logic [gpio_pkg::gpio_w-1 : 0]     gpd       // pin direction
);

    gpio_pkg::gpio_req_t req;
    gpio_pkg::gpio_rsp_t rsp;
    logic                access;                    // psel and penable both up

    assign access   = psel && penable;

    assign req.addr = paddr;
    assign req.we   = access && pwrite;
    assign req.re   = access && !pwrite;
    assign req.wd   = pwdata;

    assign pready   = penable;                      // done in first access cycle
    assign pslverr  = access && rsp.bad;
    assign prdata   = rsp.rd;                       // core zeroes it outside reads

    gpio
    gpio_0
    (
        .clk        ( pclk      ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .rsp        ( rsp       ),
        .irq        ( irq       ),
        .gpi        ( gpi       ),
        .gpo        ( gpo       ),
        .gpd        ( gpd       )
    );

    // apb protocol checks on the master side
    a_penable_needs_psel : assert property (
        @(posedge pclk) disable iff (!rst_n)
        penable |-> psel
    );

    a_paddr_stable : assert property (
        @(posedge pclk) disable iff (!rst_n)
        (psel && !penable) |=> $stable(paddr)
    );

endmodule : gpio_apb

//--- hw/gpio.sv
/*
 * GPIO register core.
 * Decodes one register access from the bus adapter, sends write strobes
 * to the output and input event blocks, returns the selected register
 * and flags unmapped addresses and writes to the input register.
 */

`timescale 1ns/1ns

module gpio (
    input  logic                              clk,    // core clock
    input  logic                              rst_n,  // sync reset, active low
    input  gpio_pkg::gpio_req_t               req,    // register access
    output gpio_pkg::gpio_rsp_t               rsp,    // read data and error
    output logic                              irq,    // level interrupt
    input  logic [gpio_pkg::gpio_w-1 : 0]     gpi,    // pin input
    output logic [gpio_pkg::gpio_w-1 : 0]     gpo,    // pin output data
    output logic [gpio_pkg::gpio_w-1 : 0]     gpd     // pin direction
);

    gpio_pkg::gpio_reg_e           reg_addr;   // address seen as register
    gpio_pkg::gpio_wr_t            wr;         // strobes to both blocks
    logic                          mapped;     // address hits a register
    logic                          wr_ok;      // write allowed this cycle
    logic [gpio_pkg::gpio_w-1 : 0] rd_sel;     // selected register value
    logic [gpio_pkg::gpio_w-1 : 0] gpi_sync;
    logic [gpio_pkg::gpio_w-1 : 0] irq_en;
    logic [gpio_pkg::gpio_w-1 : 0] irq_pol;
    logic [gpio_pkg::gpio_w-1 : 0] irq_st;

    assign reg_addr = gpio_pkg::gpio_reg_e'(req.addr);

    // address decode and read mux
    always_comb begin
        mapped = 1'b1;
        rd_sel = '0;                               // unmapped reads give 0
        case (reg_addr)
            gpio_pkg::reg_gpo     : rd_sel = gpo;
            gpio_pkg::reg_gpd     : rd_sel = gpd;
            gpio_pkg::reg_gpi     : rd_sel = gpi_sync;
            gpio_pkg::reg_irq_en  : rd_sel = irq_en;
            gpio_pkg::reg_irq_pol : rd_sel = irq_pol;
            gpio_pkg::reg_irq_st  : rd_sel = irq_st;
            default               : mapped = 1'b0;
        endcase
    end

    assign rsp.bad = !mapped || (req.we && (reg_addr == gpio_pkg::reg_gpi));
    assign rsp.rd  = req.re ? {{(32 - gpio_pkg::gpio_w){1'b0}}, rd_sel} : '0;

    assign wr_ok     = req.we && !rsp.bad;          // bad writes dropped here
    assign wr.gpo_we = wr_ok && (reg_addr == gpio_pkg::reg_gpo);
    assign wr.gpd_we = wr_ok && (reg_addr == gpio_pkg::reg_gpd);
    assign wr.en_we  = wr_ok && (reg_addr == gpio_pkg::reg_irq_en);
    assign wr.pol_we = wr_ok && (reg_addr == gpio_pkg::reg_irq_pol);
    assign wr.st_we  = wr_ok && (reg_addr == gpio_pkg::reg_irq_st);
    assign wr.data   = req.wd[gpio_pkg::gpio_w-1 : 0];   // upper bits ignored

    gpio_out_regs
    gpio_out_regs_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .wr         ( wr        ),
        .gpo        ( gpo       ),
        .gpd        ( gpd       )
    );

    gpio_in_event
    gpio_in_event_0
    (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .wr         ( wr        ),
        .gpi        ( gpi       ),
        .gpi_sync   ( gpi_sync  ),
        .irq_en     ( irq_en    ),
        .irq_pol    ( irq_pol   ),
        .irq_st     ( irq_st    ),
        .irq        ( irq       )
    );

    // an enable write shows in the input block one edge later
    a_en_write_lands : assert property (
        @(posedge clk) disable iff (!rst_n)
        wr.en_we |=> (irq_en == $past(wr.data))
    );

endmodule : gpio

//--- hw/gpio_in_event.sv
/*
 * Input side of the GPIO core.
 * Pins pass a two flop synchronizer, the synced value is compared with
 * the previous sample and edges of the selected polarity set status bits.
 * The interrupt is the OR of enabled status bits.
 */

`timescale 1ns/1ns

module gpio_in_event (
    input  logic                              clk,      // core clock
    input  logic                              rst_n,    // sync reset, active low
    input  gpio_pkg::gpio_wr_t                wr,       // decoded write strobes
    input  logic [gpio_pkg::gpio_w-1 : 0]     gpi,      // raw pin input
    output logic [gpio_pkg::gpio_w-1 : 0]     gpi_sync, // second sync stage
    output logic [gpio_pkg::gpio_w-1 : 0]     irq_en,   // per pin enable
    output logic [gpio_pkg::gpio_w-1 : 0]     irq_pol,  // per pin edge select
    output logic [gpio_pkg::gpio_w-1 : 0]     irq_st,   // sticky status
    output logic                              irq       // level interrupt
);

    logic [gpio_pkg::gpio_w-1 : 0] meta;       // first sync stage
    logic [gpio_pkg::gpio_w-1 : 0] prev;       // sample one cycle older
    logic [gpio_pkg::gpio_w-1 : 0] rise;       // 0 -> 1 seen this cycle
    logic [gpio_pkg::gpio_w-1 : 0] fall;       // 1 -> 0 seen this cycle
    logic [gpio_pkg::gpio_w-1 : 0] evt;        // edge matching polarity
    logic [gpio_pkg::gpio_w-1 : 0] clr;        // w1c mask

    // synchronizer and edge history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta     <= '0;                        // high pin gives one rise later
            gpi_sync <= '0;
            prev     <= '0;
        end else begin
            meta     <= gpi;
            gpi_sync <= meta;
            prev     <= gpi_sync;
        end
    end

    assign rise = gpi_sync & ~prev;
    assign fall = ~gpi_sync & prev;
    assign evt  = (irq_pol & rise) | (~irq_pol & fall);   // enable not applied here

    assign clr = wr.st_we ? wr.data : '0;

    // enable and polarity
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_en  <= '0;
            irq_pol <= '0;                         // falling edge by default
        end else begin
            if (wr.en_we) begin
                irq_en <= wr.data;
            end
            if (wr.pol_we) begin
                irq_pol <= wr.data;
            end
        end
    end

    // status, a new edge beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_st <= '0;
        end else begin
            irq_st <= (irq_st & ~clr) | evt;
        end
    end

    assign irq = |(irq_st & irq_en);            // follows status, no flop

    // status bits only drop after a w1c write
    a_st_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        (($past(irq_st) & ~irq_st) != '0) |-> $past(wr.st_we)
    );

endmodule : gpio_in_event

//--- hw/gpio_out_regs.sv
/*
 * Output data and direction registers of the GPIO core.
 * Each register loads from the decoded write payload on its own strobe
 * and drives the pins straight from the flop.
 */

`timescale 1ns/1ns

module gpio_out_regs (
    input  logic                              clk,    // core clock
    input  logic                              rst_n,  // sync reset, active low
    input  gpio_pkg::gpio_wr_t                wr,     // decoded write strobes
    output logic [gpio_pkg::gpio_w-1 : 0]     gpo,    // pin output data
    output logic [gpio_pkg::gpio_w-1 : 0]     gpd     // pin direction
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpo <= '0;                               // pins idle low
        end else if (wr.gpo_we) begin
            gpo <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpd <= '0;                               // all inputs after reset
        end else if (wr.gpd_we) begin
            gpd <= wr.data;
        end
    end

    // pin data only moves right after a register write or a reset
    a_gpo_write_only : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(gpo) |-> ($past(wr.gpo_we) || $past(!rst_n))
    );

endmodule : gpio_out_regs

//--- hw/gpio_pkg.sv
/*
 * Shared definitions for the APB GPIO peripheral.
 * Holds the pin count, the register word map and the structs that carry
 * register accesses between the APB adapter, the core and its two blocks.
 * Referenced by scoped names only.
 */

package gpio_pkg;

    localparam integer gpio_w = 8;              // number of pins

    // register word addresses
    typedef enum logic [4 : 0] {
        reg_gpo     = 5'h00,                    // output data, rw
        reg_gpd     = 5'h04,                    // direction, rw, 1 = out
        reg_gpi     = 5'h08,                    // synced input, ro
        reg_irq_en  = 5'h0C,                    // irq enable, rw
        reg_irq_pol = 5'h10,                    // 1 = rising, 0 = falling
        reg_irq_st  = 5'h14                     // status, w1c
    } gpio_reg_e;

    // one register access, adapter to core
    typedef struct packed {
        logic [4 : 0]  addr;                    // word address
        logic          we;                      // write strobe, 1 cycle
        logic          re;                      // read strobe, 1 cycle
        logic [31 : 0] wd;                      // write data
    } gpio_req_t;

    // core answer to the adapter
    typedef struct packed {
        logic [31 : 0] rd;                      // read data, zero extended
        logic          bad;                     // unmapped or ro write
    } gpio_rsp_t;

    // decoded write strobes from core to its blocks
    typedef struct packed {
        logic                gpo_we;            // output data load
        logic                gpd_we;            // direction load
        logic                en_we;             // irq enable load
        logic                pol_we;            // polarity load
        logic                st_we;             // status w1c
        logic [gpio_w-1 : 0] data;              // payload, low bits of pwdata
    } gpio_wr_t;

endpackage : gpio_pkg
